/* hawk_rd_top.f */
rtl/hacd_pkg.sv
rtl/att_entry.sv
rtl/att_hit_resolve.sv
rtl/att_lookup_ctrl.sv
rtl/cpu_stall_rd.sv
rtl/hawk_rd_top.sv
tb/tb_hawk_rd_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_hawk_rd_top \
    -f hawk_rd_top.f

# Result is judged from the log contents
./obj_dir/Vtb_hawk_rd_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Run passed"
    exit 0
else
    echo "Run failed"
    exit 1
fi

/* tb/tb_hawk_rd_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench, one request in flight at a time
// Memory model answers with the received address as read data
// Fills use entries 0, 1, 2 in order, so the table rows need unique pages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_hawk_rd_top;
    import hacd_pkg::*;

    localparam int NROWS   = 8;
    localparam int TIMEOUT = 200;
    // Physical page that answers with SLVERR
    localparam logic [PPN_W-1:0] ERR_PAGE = 20'h0BAD0;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic              bypass;
        logic              exp_miss;
        logic [PPN_W-1:0]  fill_ppa;
        logic [ADDR_W-1:0] exp_addr;
    } row_t;

    logic                clk;
    logic                rst;
    logic                hawk_inactive;
    logic [ID_W-1:0]     s_axi_arid;
    logic [ADDR_W-1:0]   s_axi_araddr;
    logic [7:0]          s_axi_arlen;
    logic                s_axi_arvalid;
    logic                s_axi_arready;
    logic [ID_W-1:0]     s_axi_rid;
    logic [DATA_W-1:0]   s_axi_rdata;
    logic [1:0]          s_axi_rresp;
    logic                s_axi_rlast;
    logic                s_axi_rvalid;
    logic                s_axi_rready;
    logic [ID_W-1:0]     m_axi_arid;
    logic [ADDR_W-1:0]   m_axi_araddr;
    logic [7:0]          m_axi_arlen;
    logic                m_axi_arvalid;
    logic                m_axi_arready;
    logic [ID_W-1:0]     m_axi_rid;
    logic [DATA_W-1:0]   m_axi_rdata;
    logic [1:0]          m_axi_rresp;
    logic                m_axi_rlast;
    logic                m_axi_rvalid;
    logic                m_axi_rready;
    logic                att_miss;
    logic [PPN_W-1:0]    miss_ppn;
    logic                fill_valid;
    logic [ATT_IDX_W-1:0] fill_idx;
    logic [PPN_W-1:0]    fill_ppn;
    logic [PPN_W-1:0]    fill_ppa;
    logic [CNT_W-1:0]    req_count0;
    logic [CNT_W-1:0]    req_count1;
    logic [CNT_W-1:0]    resp_count0;
    logic [CNT_W-1:0]    resp_count1;
    logic                bus_error;

    row_t                rows [NROWS];
    row_t                cur;
    integer              seed;
    int                  resp_done;
    int                  beat_idx;
    int                  exp_req [4];
    int                  exp_okay [4];
    logic [ADDR_W-1:0]   q_addr [$];
    logic [ID_W-1:0]     q_id [$];
    logic [7:0]          q_len [$];

    hawk_rd_top u_hawk_rd_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_fail(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_fail($sformatf("** Error at %0t ns: %s got 0x%0h, expected 0x%0h",
                                     $time, what, got, exp));
        end
    endtask

    // Memory side slave with random arready, CPU side read data checks
    initial begin : mem_model
        logic              ar_fire;
        logic              r_fire;
        logic [ADDR_W-1:0] rsp_addr;
        logic [7:0]        rsp_len;
        seed          = 72948;
        m_axi_arready = 1'b0;
        m_axi_rid     = '0;
        m_axi_rdata   = '0;
        m_axi_rresp   = 2'b00;
        m_axi_rlast   = 1'b0;
        m_axi_rvalid  = 1'b0;
        s_axi_rready  = 1'b0;
        resp_done     = 0;
        beat_idx      = 0;
        rsp_len       = '0;
        forever begin
            @(posedge clk);
            ar_fire = m_axi_arvalid && m_axi_arready;
            r_fire  = m_axi_rvalid && m_axi_rready;
            // R channel handshake passes straight through both ways
            check_eq("s_axi_rvalid", 64'(s_axi_rvalid), 64'(m_axi_rvalid));
            check_eq("m_axi_rready", 64'(m_axi_rready), 64'(s_axi_rready));
            if (ar_fire) begin
                q_addr.push_back(m_axi_araddr);
                q_id.push_back(m_axi_arid);
                q_len.push_back(m_axi_arlen);
            end
            if (r_fire) begin
                check_eq("s_axi_rdata", s_axi_rdata, 64'(cur.exp_addr));
                check_eq("s_axi_rid", 64'(s_axi_rid), 64'(cur.id));
                check_eq("s_axi_rresp", 64'(s_axi_rresp),
                         (cur.exp_addr[ADDR_W-1:PAGE_SHIFT] == ERR_PAGE) ? 64'd2 : 64'd0);
                check_eq("s_axi_rlast", 64'(s_axi_rlast), 64'(beat_idx == int'(cur.len)));
                if (s_axi_rlast) begin
                    resp_done++;
                end
            end
            @(negedge clk);
            if (r_fire) begin
                if (m_axi_rlast) begin
                    m_axi_rvalid = 1'b0;
                    m_axi_rlast  = 1'b0;
                end else begin
                    beat_idx++;
                    m_axi_rlast = (beat_idx == int'(rsp_len));
                end
            end
            if (!m_axi_rvalid && q_addr.size() != 0) begin
                rsp_addr     = q_addr.pop_front();
                rsp_len      = q_len.pop_front();
                m_axi_rid    = q_id.pop_front();
                m_axi_rdata  = DATA_W'(rsp_addr);
                m_axi_rresp  = (rsp_addr[ADDR_W-1:PAGE_SHIFT] == ERR_PAGE) ? 2'b10 : 2'b00;
                beat_idx     = 0;
                m_axi_rlast  = (rsp_len == 8'd0);
                m_axi_rvalid = 1'b1;
            end
            m_axi_arready = (($random(seed) & 3) != 0);
            s_axi_rready  = (($random(seed) & 3) != 0);
        end
    end

    initial begin : main_seq
        int   wait_cnt;
        int   fill_next;
        logic saw_miss;
        rst           = 1'b1;
        hawk_inactive = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arvalid = 1'b0;
        fill_valid    = 1'b0;
        fill_idx      = '0;
        fill_ppn      = '0;
        fill_ppa      = '0;
        fill_next     = 0;
        for (int k = 0; k < 4; k++) begin
            exp_req[k]  = 0;
            exp_okay[k] = 0;
        end

        // id, addr, len, bypass, miss expected, fill page, expected downstream addr
        rows[0] = '{2'd0, 32'h1234_5678, 8'd0, 1'b0, 1'b1, 20'hABCDE, 32'hABCD_E678};
        rows[1] = '{2'd1, 32'h1234_5ABC, 8'd1, 1'b0, 1'b0, 20'h00000, 32'hABCD_EABC};
        rows[2] = '{2'd1, 32'h0002_0010, 8'd0, 1'b1, 1'b0, 20'h00000, 32'h0002_0010};
        rows[3] = '{2'd0, 32'h7777_7FF0, 8'd2, 1'b0, 1'b1, 20'h00042, 32'h0004_2FF0};
        rows[4] = '{2'd1, 32'h0BAD_0040, 8'd0, 1'b1, 1'b0, 20'h00000, 32'h0BAD_0040};
        rows[5] = '{2'd0, 32'h1234_5000, 8'd1, 1'b0, 1'b0, 20'h00000, 32'hABCD_E000};
        rows[6] = '{2'd2, 32'h5555_5123, 8'd0, 1'b0, 1'b1, 20'h0BAD0, 32'h0BAD_0123};
        rows[7] = '{2'd1, 32'h7777_7004, 8'd0, 1'b0, 1'b0, 20'h00000, 32'h0004_2004};

        // Outputs stay quiet while reset is held
        repeat (5) begin
            @(negedge clk);
            check_eq("s_axi_arready in reset", 64'(s_axi_arready), 64'd0);
            check_eq("m_axi_arvalid in reset", 64'(m_axi_arvalid), 64'd0);
            check_eq("att_miss in reset", 64'(att_miss), 64'd0);
        end
        rst = 1'b0;

        for (int i = 0; i < NROWS; i++) begin
            @(negedge clk);
            cur = rows[i];
            exp_req[cur.id]++;
            if (cur.exp_addr[ADDR_W-1:PAGE_SHIFT] != ERR_PAGE) begin
                exp_okay[cur.id] += int'(cur.len) + 1;
            end
            hawk_inactive = cur.bypass;
            s_axi_arid    = cur.id;
            s_axi_araddr  = cur.addr;
            s_axi_arlen   = cur.len;
            s_axi_arvalid = 1'b1;

            wait_cnt = 0;
            forever begin
                @(posedge clk);
                if (s_axi_arready) break;
                wait_cnt++;
                if (wait_cnt > TIMEOUT) stop_with_fail("Timeout waiting for s_axi_arready");
            end
            @(negedge clk);
            s_axi_arvalid = 1'b0;

            // Translation, one fill allowed on a miss
            saw_miss = 1'b0;
            wait_cnt = 0;
            forever begin
                @(posedge clk);
                wait_cnt++;
                if (m_axi_arvalid) break;
                if (att_miss) begin
                    check_eq("att_miss raised", 64'd1, 64'(cur.exp_miss));
                    check_eq("att_miss after fill", 64'(saw_miss), 64'd0);
                    check_eq("miss_ppn", 64'(miss_ppn), 64'(cur.addr[ADDR_W-1:PAGE_SHIFT]));
                    saw_miss = 1'b1;
                    @(negedge clk);
                    fill_valid = 1'b1;
                    fill_idx   = ATT_IDX_W'(fill_next);
                    fill_ppn   = cur.addr[ADDR_W-1:PAGE_SHIFT];
                    fill_ppa   = cur.fill_ppa;
                    @(negedge clk);
                    fill_valid = 1'b0;
                    fill_next++;
                end
                if (wait_cnt > TIMEOUT) stop_with_fail("Timeout waiting for m_axi_arvalid");
            end
            check_eq("att_miss seen", 64'(saw_miss), 64'(cur.exp_miss));
            if (cur.bypass) begin
                check_eq("bypass latency", 64'(wait_cnt), 64'd1);
            end
            check_eq("m_axi_araddr", 64'(m_axi_araddr), 64'(cur.exp_addr));
            check_eq("m_axi_arid", 64'(m_axi_arid), 64'(cur.id));
            check_eq("m_axi_arlen", 64'(m_axi_arlen), 64'(cur.len));

            // Address held under arready back-pressure
            wait_cnt = 0;
            while (!m_axi_arready) begin
                @(posedge clk);
                check_eq("m_axi_arvalid held", 64'(m_axi_arvalid), 64'd1);
                check_eq("m_axi_araddr held", 64'(m_axi_araddr), 64'(cur.exp_addr));
                wait_cnt++;
                if (wait_cnt > TIMEOUT) stop_with_fail("Timeout waiting for m_axi_arready");
            end

            wait_cnt = 0;
            forever begin
                @(negedge clk);
                if (resp_done == i + 1) break;
                wait_cnt++;
                if (wait_cnt > TIMEOUT) stop_with_fail("Timeout waiting for read response");
            end
        end

        check_eq("req_count0", 64'(req_count0), 64'(exp_req[0]));
        check_eq("req_count1", 64'(req_count1), 64'(exp_req[1]));
        check_eq("resp_count0", 64'(resp_count0), 64'(exp_okay[0]));
        check_eq("resp_count1", 64'(resp_count1), 64'(exp_okay[1]));
        check_eq("bus_error", 64'(bus_error), 64'd1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* rtl/hawk_rd_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read bridge with translation table
// Fill tags must not duplicate an existing entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hawk_rd_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            hawk_inactive,
    input  logic [hacd_pkg::ID_W-1:0]       s_axi_arid,
    input  logic [hacd_pkg::ADDR_W-1:0]     s_axi_araddr,
    input  logic [7:0]                      s_axi_arlen,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [hacd_pkg::ID_W-1:0]       s_axi_rid,
    output logic [hacd_pkg::DATA_W-1:0]     s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rlast,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,
    output logic [hacd_pkg::ID_W-1:0]       m_axi_arid,
    output logic [hacd_pkg::ADDR_W-1:0]     m_axi_araddr,
    output logic [7:0]                      m_axi_arlen,
    output logic                            m_axi_arvalid,
    input  logic                            m_axi_arready,
    input  logic [hacd_pkg::ID_W-1:0]       m_axi_rid,
    input  logic [hacd_pkg::DATA_W-1:0]     m_axi_rdata,
    input  logic [1:0]                      m_axi_rresp,
    input  logic                            m_axi_rlast,
    input  logic                            m_axi_rvalid,
    output logic                            m_axi_rready,
    output logic                            att_miss,
    output logic [hacd_pkg::PPN_W-1:0]      miss_ppn,
    input  logic                            fill_valid,
    input  logic [hacd_pkg::ATT_IDX_W-1:0]  fill_idx,
    input  logic [hacd_pkg::PPN_W-1:0]      fill_ppn,
    input  logic [hacd_pkg::PPN_W-1:0]      fill_ppa,
    output logic [hacd_pkg::CNT_W-1:0]      req_count0,
    output logic [hacd_pkg::CNT_W-1:0]      req_count1,
    output logic [hacd_pkg::CNT_W-1:0]      resp_count0,
    output logic [hacd_pkg::CNT_W-1:0]      resp_count1,
    output logic                            bus_error
);
    import hacd_pkg::*;

    logic                                  lookup_req;
    logic [PPN_W-1:0]                      lookup_ppn;
    logic                                  lookup_strobe;
    logic [PPN_W-1:0]                      lookup_tag;
    logic                                  any_hit;
    logic                                  grant;
    logic [PPN_W-1:0]                      grant_ppa;
    logic [ATT_ENTRIES-1:0]                fill_sel;
    logic [ATT_ENTRIES-1:0]                entry_hit;
    logic [ATT_ENTRIES-1:0][PPN_W-1:0]     entry_ppa;

    // Index to one-hot entry select
    assign fill_sel = {{(ATT_ENTRIES-1){1'b0}}, 1'b1} << fill_idx;

    cpu_stall_rd u_cpu_stall_rd (
        .clk           (clk),
        .rst           (rst),
        .hawk_inactive (hawk_inactive),
        .s_axi_arid    (s_axi_arid),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arlen   (s_axi_arlen),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rid     (s_axi_rid),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rlast   (s_axi_rlast),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .m_axi_arid    (m_axi_arid),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arlen   (m_axi_arlen),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_rid     (m_axi_rid),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rresp   (m_axi_rresp),
        .m_axi_rlast   (m_axi_rlast),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready),
        .lookup_req    (lookup_req),
        .lookup_ppn    (lookup_ppn),
        .grant         (grant),
        .grant_ppa     (grant_ppa),
        .req_count0    (req_count0),
        .req_count1    (req_count1),
        .resp_count0   (resp_count0),
        .resp_count1   (resp_count1),
        .bus_error     (bus_error)
    );

    att_lookup_ctrl u_att_lookup_ctrl (
        .clk           (clk),
        .rst           (rst),
        .lookup_req    (lookup_req),
        .lookup_ppn    (lookup_ppn),
        .any_hit       (any_hit),
        .fill_valid    (fill_valid),
        .lookup_strobe (lookup_strobe),
        .lookup_tag    (lookup_tag),
        .att_miss      (att_miss),
        .miss_ppn      (miss_ppn)
    );

    for (genvar i = 0; i < ATT_ENTRIES; i++) begin : g_entry
        att_entry u_att_entry (
            .clk           (clk),
            .rst           (rst),
            .fill_valid    (fill_valid),
            .fill_sel      (fill_sel[i]),
            .fill_ppn      (fill_ppn),
            .fill_ppa      (fill_ppa),
            .lookup_strobe (lookup_strobe),
            .lookup_tag    (lookup_tag),
            .hit           (entry_hit[i]),
            .ppa           (entry_ppa[i])
        );
    end

    att_hit_resolve u_att_hit_resolve (
        .entry_hit (entry_hit),
        .entry_ppa (entry_ppa),
        .any_hit   (any_hit),
        .grant     (grant),
        .grant_ppa (grant_ppa)
    );

endmodule

/* rtl/cpu_stall_rd.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One outstanding read address at a time, held until translated
// R channel is a combinational pass-through
// Counters track IDs 0 and 1 only
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_stall_rd (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hawk_inactive,
    // CPU side AR
    input  logic [hacd_pkg::ID_W-1:0]     s_axi_arid,
    input  logic [hacd_pkg::ADDR_W-1:0]   s_axi_araddr,
    input  logic [7:0]                    s_axi_arlen,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    // CPU side R
    output logic [hacd_pkg::ID_W-1:0]     s_axi_rid,
    output logic [hacd_pkg::DATA_W-1:0]   s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rlast,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,
    // Memory side AR
    output logic [hacd_pkg::ID_W-1:0]     m_axi_arid,
    output logic [hacd_pkg::ADDR_W-1:0]   m_axi_araddr,
    output logic [7:0]                    m_axi_arlen,
    output logic                          m_axi_arvalid,
    input  logic                          m_axi_arready,
    // Memory side R
    input  logic [hacd_pkg::ID_W-1:0]     m_axi_rid,
    input  logic [hacd_pkg::DATA_W-1:0]   m_axi_rdata,
    input  logic [1:0]                    m_axi_rresp,
    input  logic                          m_axi_rlast,
    input  logic                          m_axi_rvalid,
    output logic                          m_axi_rready,
    // Translation unit
    output logic                          lookup_req,
    output logic [hacd_pkg::PPN_W-1:0]    lookup_ppn,
    input  logic                          grant,
    input  logic [hacd_pkg::PPN_W-1:0]    grant_ppa,
    // Debug
    output logic [hacd_pkg::CNT_W-1:0]    req_count0,
    output logic [hacd_pkg::CNT_W-1:0]    req_count1,
    output logic [hacd_pkg::CNT_W-1:0]    resp_count0,
    output logic [hacd_pkg::CNT_W-1:0]    resp_count1,
    output logic                          bus_error
);
    import hacd_pkg::*;

    stall_state_e        state;
    logic                arready_q;
    logic [ID_W-1:0]     arid_q;
    logic [ADDR_W-1:0]   araddr_q;
    logic [7:0]          arlen_q;
    logic                ar_hs;
    logic                r_hs;

    assign ar_hs = s_axi_arvalid & arready_q;
    assign r_hs  = s_axi_rvalid & s_axi_rready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= STALL_IDLE;
            arready_q <= 1'b0;
        end else begin
            case (state)
                STALL_IDLE: begin
                    if (ar_hs) begin
                        arready_q <= 1'b0;
                        // Bypass skips the table entirely
                        state     <= hawk_inactive ? STALL_ISSUE : STALL_WAIT;
                    end else begin
                        arready_q <= 1'b1;
                    end
                end
                STALL_WAIT: begin
                    if (grant) begin
                        state <= STALL_ISSUE;
                    end
                end
                STALL_ISSUE: begin
                    if (m_axi_arready) begin
                        state <= STALL_IDLE;
                    end
                end
                default: state <= STALL_IDLE;
            endcase
        end
    end

    // Request payload, page bits swapped on grant
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            arid_q   <= s_axi_arid;
            araddr_q <= s_axi_araddr;
            arlen_q  <= s_axi_arlen;
        end else if (state == STALL_WAIT && grant) begin
            araddr_q[ADDR_W-1:PAGE_SHIFT] <= grant_ppa;
        end
    end

    assign s_axi_arready = arready_q;
    assign m_axi_arvalid = (state == STALL_ISSUE);
    assign m_axi_arid    = arid_q;
    assign m_axi_araddr  = araddr_q;
    assign m_axi_arlen   = arlen_q;

    assign lookup_req = (state == STALL_WAIT);
    assign lookup_ppn = araddr_q[ADDR_W-1:PAGE_SHIFT];

    assign s_axi_rid    = m_axi_rid;
    assign s_axi_rdata  = m_axi_rdata;
    assign s_axi_rresp  = m_axi_rresp;
    assign s_axi_rlast  = m_axi_rlast;
    assign s_axi_rvalid = m_axi_rvalid;
    assign m_axi_rready = s_axi_rready;

    // Per-ID request and OKAY response counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_count0  <= '0;
            req_count1  <= '0;
            resp_count0 <= '0;
            resp_count1 <= '0;
            bus_error   <= 1'b0;
        end else begin
            if (ar_hs && s_axi_arid == ID_W'(0)) begin
                req_count0 <= req_count0 + 1'b1;
            end
            if (ar_hs && s_axi_arid == ID_W'(1)) begin
                req_count1 <= req_count1 + 1'b1;
            end
            if (r_hs && s_axi_rresp == 2'b00 && s_axi_rid == ID_W'(0)) begin
                resp_count0 <= resp_count0 + 1'b1;
            end
            if (r_hs && s_axi_rresp == 2'b00 && s_axi_rid == ID_W'(1)) begin
                resp_count1 <= resp_count1 + 1'b1;
            end
            if (r_hs && s_axi_rresp != 2'b00) begin
                bus_error <= 1'b1;
            end
        end
    end

    // Held request must not change under back-pressure
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
        else $error("m_axi_araddr changed while stalled");

endmodule

/* rtl/att_lookup_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial lookup sequencer, one page at a time
// A miss waits for any fill strobe, then retries
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module att_lookup_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          lookup_req,
    input  logic [hacd_pkg::PPN_W-1:0]    lookup_ppn,
    input  logic                          any_hit,
    input  logic                          fill_valid,
    output logic                          lookup_strobe,
    output logic [hacd_pkg::PPN_W-1:0]    lookup_tag,
    output logic                          att_miss,
    output logic [hacd_pkg::PPN_W-1:0]    miss_ppn
);
    import hacd_pkg::*;

    att_state_e         state;
    logic [PPN_W-1:0]   tag_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= ATT_IDLE;
            lookup_strobe <= 1'b0;
        end else begin
            lookup_strobe <= 1'b0;
            case (state)
                ATT_IDLE: begin
                    if (lookup_req) begin
                        lookup_strobe <= 1'b1;
                        state         <= ATT_LOOKUP;
                    end
                end
                ATT_LOOKUP: begin
                    // Entry hits are valid the cycle after the strobe
                    if (!lookup_strobe) begin
                        state <= any_hit ? ATT_DONE : ATT_MISS;
                    end
                end
                ATT_MISS: begin
                    if (fill_valid) begin
                        lookup_strobe <= 1'b1;
                        state         <= ATT_LOOKUP;
                    end
                end
                ATT_DONE: begin
                    if (!lookup_req) begin
                        state <= ATT_IDLE;
                    end
                end
                default: state <= ATT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ATT_IDLE && lookup_req) begin
            tag_q <= lookup_ppn;
        end
    end

    assign lookup_tag = tag_q;
    assign att_miss   = (state == ATT_MISS);
    assign miss_ppn   = tag_q;

endmodule

/* rtl/att_hit_resolve.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational hit select, lowest index wins
// Table tags are expected to be unique
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module att_hit_resolve (
    input  logic [hacd_pkg::ATT_ENTRIES-1:0]                     entry_hit,
    input  logic [hacd_pkg::ATT_ENTRIES-1:0][hacd_pkg::PPN_W-1:0] entry_ppa,
    output logic                                                 any_hit,
    output logic                                                 grant,
    output logic [hacd_pkg::PPN_W-1:0]                           grant_ppa
);
    import hacd_pkg::*;

    // Scan downwards so the lowest hit is the last one taken
    always_comb begin
        grant_ppa = '0;
        for (int i = ATT_ENTRIES - 1; i >= 0; i--) begin
            if (entry_hit[i]) begin
                grant_ppa = entry_ppa[i];
            end
        end
    end

    assign any_hit = |entry_hit;
    assign grant   = any_hit;

    // Duplicate tags in the table would give several hits
    always_comb begin
        a_hit_onehot: assert ($onehot0(entry_hit))
            else $error("multiple table entries hit");
    end

endmodule

/* rtl/att_entry.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One table entry, hit registered a cycle after the strobe
// A fill in the strobe cycle is not seen by that lookup
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module att_entry (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fill_valid,
    input  logic                          fill_sel,
    input  logic [hacd_pkg::PPN_W-1:0]    fill_ppn,
    input  logic [hacd_pkg::PPN_W-1:0]    fill_ppa,
    input  logic                          lookup_strobe,
    input  logic [hacd_pkg::PPN_W-1:0]    lookup_tag,
    output logic                          hit,
    output logic [hacd_pkg::PPN_W-1:0]    ppa
);
    import hacd_pkg::*;

    logic               valid_q;
    logic [PPN_W-1:0]   tag_q;
    logic [PPN_W-1:0]   ppa_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            hit     <= 1'b0;
        end else begin
            if (fill_valid && fill_sel) begin
                valid_q <= 1'b1;
            end
            // Single-cycle pulse per strobe
            hit <= lookup_strobe && valid_q && (tag_q == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid && fill_sel) begin
            tag_q <= fill_ppn;
            ppa_q <= fill_ppa;
        end
    end

    assign ppa = ppa_q;

endmodule

/* rtl/hacd_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and FSM encodings for the read bridge
// Page size is fixed at 4 KB, ATT_ENTRIES must equal 2**ATT_IDX_W
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hacd_pkg;

    // AXI read channel widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int ID_W   = 2;

    // 4 KB pages
    localparam int PAGE_SHIFT = 12;
    localparam int PPN_W      = ADDR_W - PAGE_SHIFT;

    // Translation table
    localparam int ATT_ENTRIES = 4;
    localparam int ATT_IDX_W   = 2;

    // Debug counter width, wraps silently
    localparam int CNT_W = 16;

    typedef enum logic [1:0] {
        STALL_IDLE  = 2'd0,
        STALL_WAIT  = 2'd1,
        STALL_ISSUE = 2'd2
    } stall_state_e;

    typedef enum logic [1:0] {
        ATT_IDLE   = 2'd0,
        ATT_LOOKUP = 2'd1,
        ATT_MISS   = 2'd2,
        ATT_DONE   = 2'd3
    } att_state_e;

endpackage
